// ==== hw/lz_cfg_pkg.sv ====
package lz_cfg_pkg;

  localparam int ADDR_WIDTH = 16;
  localparam int HASH_BITS = 4;
  localparam int NUM_ROWS = 2 ** HASH_BITS;
  localparam int DEFAULT_ROW_SIZE = 4;

  // Bytes compared per candidate, and the data word that carries them.
  localparam int PREFIX_BYTES = 4;
  localparam int DATA_WIDTH = PREFIX_BYTES * 8;

  localparam int LEN_WIDTH = $clog2(PREFIX_BYTES + 1); // Holds 0 to PREFIX_BYTES.

  // Index width for a table of the given size, never below one bit.
  function automatic int slot_width(input int entries);
    return (entries > 1) ? $clog2(entries) : 1;
  endfunction

endpackage

// ==== hw/lz_types_pkg.sv ====
package lz_types_pkg;

  import lz_cfg_pkg::*;

  // One remembered position in a hash row.
  typedef struct packed {
    logic                    valid;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   prefix; // Byte 0 sits in the low bits.
  } hist_entry_t;

  // A scored history entry, as it travels through the selection tree.
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
    logic                  can_ext;
  } match_cand_t;

endpackage

// ==== hw/row_access_if.sv ====
`timescale 1ns/1ps

interface row_access_if import lz_cfg_pkg::*, lz_types_pkg::*; #(
  parameter int ROW_SIZE = DEFAULT_ROW_SIZE
) ();

  localparam int SLOT_W = slot_width(ROW_SIZE);

  logic                       req;
  logic                       we;
  logic [HASH_BITS-1:0]       row;
  logic [SLOT_W-1:0]          slot;
  hist_entry_t                wentry;
  logic                       gnt;
  hist_entry_t [ROW_SIZE-1:0] rdata; // Whole row from the last served read.

  modport requester (output req, we, row, slot, wentry, input gnt, rdata);
  modport arbiter (input req, we, row, slot, wentry, output gnt, rdata);

endinterface

// ==== hw/hash_row_table.sv ====
`timescale 1ns/1ps

module hash_row_table import lz_cfg_pkg::*, lz_types_pkg::*; #(
  parameter int ROW_SIZE = DEFAULT_ROW_SIZE
) (
  input logic clk,
  input logic rst_n,
  row_access_if.arbiter lk_port,
  row_access_if.arbiter ins_port
);

  localparam int SLOT_W = slot_width(ROW_SIZE);

  logic [ROW_SIZE-1:0]        vld_q [NUM_ROWS];
  hist_entry_t                mem_q [NUM_ROWS][ROW_SIZE];
  hist_entry_t [ROW_SIZE-1:0] rdata_q;
  hist_entry_t [ROW_SIZE-1:0] rd_row;

  logic                 acc_en;
  logic                 acc_we;
  logic [HASH_BITS-1:0] acc_row;
  logic [SLOT_W-1:0]    acc_slot;
  hist_entry_t          acc_entry;

  // Lookup first; the insert only gets the cycles the lookup leaves idle.
  assign lk_port.gnt = lk_port.req;
  assign ins_port.gnt = ins_port.req && !lk_port.req;
  assign acc_en = lk_port.gnt || ins_port.gnt;

  always_comb begin
    if (lk_port.gnt) begin
      acc_we = lk_port.we;
      acc_row = lk_port.row;
      acc_slot = lk_port.slot;
      acc_entry = lk_port.wentry;
    end else begin
      acc_we = ins_port.we;
      acc_row = ins_port.row;
      acc_slot = ins_port.slot;
      acc_entry = ins_port.wentry;
    end
  end

  always_comb begin
    for (int s = 0; s < ROW_SIZE; s++) begin
      rd_row[s] = mem_q[acc_row][s];
      rd_row[s].valid = vld_q[acc_row][s]; // Valid bits live apart so reset can clear them.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        vld_q[r] <= '0;
      end
    end else if (acc_en && acc_we) begin
      vld_q[acc_row][acc_slot] <= acc_entry.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_en && acc_we) begin
      mem_q[acc_row][acc_slot] <= acc_entry;
    end else if (acc_en) begin
      rdata_q <= rd_row;
    end
  end

  assign lk_port.rdata = rdata_q;
  assign ins_port.rdata = rdata_q;

  // The lookup never asks in the cycle after it is served, so inserts cannot starve.
  assert property (@(posedge clk) disable iff (!rst_n) ins_port.req |-> ##[0:2] ins_port.gnt)
    else $error("Insert request not granted within two cycles.");

endmodule

// ==== hw/hash_row_lookup.sv ====
`timescale 1ns/1ps

module hash_row_lookup import lz_cfg_pkg::*, lz_types_pkg::*; #(
  parameter int ROW_SIZE = DEFAULT_ROW_SIZE
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  logic [ADDR_WIDTH-1:0]      in_pos,
  input  logic [DATA_WIDTH-1:0]      in_data,
  output logic                       in_ready,
  input  logic                       space_ok,
  row_access_if.requester            mem,
  output logic                       cand_valid,
  output match_cand_t [ROW_SIZE-1:0] cand_row,
  output logic [ADDR_WIDTH-1:0]      cand_pos,
  output logic [DATA_WIDTH-1:0]      cand_data,
  output logic                       ins_valid,
  output logic [HASH_BITS-1:0]       ins_row,
  output logic [ADDR_WIDTH-1:0]      ins_pos,
  output logic [DATA_WIDTH-1:0]      ins_data
);

  logic                       ready_q;
  logic                       fire;
  match_cand_t [ROW_SIZE-1:0] score;

  // Byte i is shifted left by i before the XOR.
  function automatic logic [HASH_BITS-1:0] row_hash(input logic [DATA_WIDTH-1:0] d);
    logic [PREFIX_BYTES+7:0] acc;
    acc = '0;
    for (int i = 0; i < PREFIX_BYTES; i++) begin
      acc = acc ^ ((PREFIX_BYTES + 8)'(d[8*i +: 8]) << i);
    end
    return acc[HASH_BITS-1:0];
  endfunction

  function automatic logic [LEN_WIDTH-1:0] match_len(input logic [DATA_WIDTH-1:0] a,
                                                      input logic [DATA_WIDTH-1:0] b);
    logic [LEN_WIDTH-1:0] n;
    logic                 run;
    n = '0;
    run = 1'b1;
    for (int i = 0; i < PREFIX_BYTES; i++) begin
      run = run && (a[8*i +: 8] == b[8*i +: 8]);
      if (run) n = n + 1'b1;
    end
    return n;
  endfunction

  // Every other cycle at most, which keeps the table free for the insert.
  assign in_ready = ready_q && space_ok;
  assign fire = in_valid && in_ready;

  assign mem.req = fire;
  assign mem.we = 1'b0;
  assign mem.row = row_hash(in_data);
  assign mem.slot = '0;
  assign mem.wentry = '0;

  always_comb begin
    for (int s = 0; s < ROW_SIZE; s++) begin
      score[s].addr = mem.rdata[s].addr;
      score[s].len = match_len(mem.rdata[s].prefix, ins_data);
      score[s].valid = mem.rdata[s].valid && (score[s].len != '0);
      score[s].can_ext = (score[s].len == LEN_WIDTH'(PREFIX_BYTES));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
      ins_valid <= 1'b0;
      cand_valid <= 1'b0;
    end else begin
      ready_q <= !fire;
      ins_valid <= fire;
      cand_valid <= ins_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      ins_row <= mem.row;
      ins_pos <= in_pos;
      ins_data <= in_data;
    end
    if (ins_valid) begin
      cand_row <= score; // Row data from the read served one edge earlier.
      cand_pos <= ins_pos;
      cand_data <= ins_data;
    end
  end

endmodule

// ==== hw/hash_row_insert.sv ====
`timescale 1ns/1ps

module hash_row_insert import lz_cfg_pkg::*, lz_types_pkg::*; #(
  parameter int ROW_SIZE = DEFAULT_ROW_SIZE
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  ins_valid,
  input logic [HASH_BITS-1:0]  ins_row,
  input logic [ADDR_WIDTH-1:0] ins_pos,
  input logic [DATA_WIDTH-1:0] ins_data,
  row_access_if.requester      mem
);

  localparam int SLOT_W = slot_width(ROW_SIZE);

  logic [SLOT_W-1:0]    ptr_q [NUM_ROWS]; // Next victim in each row, the oldest entry.
  logic                 pend_q;
  logic [HASH_BITS-1:0] row_q;
  hist_entry_t          entry_q;
  hist_entry_t          new_entry;
  logic [HASH_BITS-1:0] wr_row;

  always_comb begin
    new_entry.valid = 1'b1;
    new_entry.addr = ins_pos;
    new_entry.prefix = ins_data;
  end

  // A request that loses arbitration is replayed from the held copy.
  assign wr_row = ins_valid ? ins_row : row_q;
  assign mem.req = ins_valid || pend_q;
  assign mem.we = 1'b1;
  assign mem.row = wr_row;
  assign mem.slot = ptr_q[wr_row];
  assign mem.wentry = ins_valid ? new_entry : entry_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
      for (int r = 0; r < NUM_ROWS; r++) begin
        ptr_q[r] <= '0;
      end
    end else begin
      pend_q <= mem.req && !mem.gnt;
      if (mem.req && mem.gnt) begin
        ptr_q[wr_row] <= (ptr_q[wr_row] == SLOT_W'(ROW_SIZE - 1)) ? '0 : ptr_q[wr_row] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ins_valid) begin
      row_q <= ins_row;
      entry_q <= new_entry;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) ins_valid |-> !pend_q)
    else $error("New insert arrived while a write was still pending.");

endmodule

// ==== hw/hash_row_merge.sv ====
`timescale 1ns/1ps

module hash_row_merge import lz_cfg_pkg::*, lz_types_pkg::*; #(
  parameter int ROW_SIZE = DEFAULT_ROW_SIZE,
  parameter int FIFO_DEPTH = $clog2(ROW_SIZE) + 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cand_valid,
  input  match_cand_t [ROW_SIZE-1:0] cand_row,
  input  logic [ADDR_WIDTH-1:0]      cand_pos,
  input  logic [DATA_WIDTH-1:0]      cand_data,
  output logic                       space_ok,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [ADDR_WIDTH-1:0]      out_pos,
  output logic [DATA_WIDTH-1:0]      out_data,
  output logic                       out_hit,
  output logic [ADDR_WIDTH-1:0]      out_match_addr,
  output logic [LEN_WIDTH-1:0]       out_match_len,
  output logic                       out_can_ext
);

  localparam int LAYER = $clog2(ROW_SIZE) + 1;
  localparam int LEAF_SIZE = 2 ** (LAYER - 1);
  localparam int TREE_SIZE = 2 * LEAF_SIZE - 1;
  localparam int BYP_W = ADDR_WIDTH + DATA_WIDTH;
  localparam int FIFO_W = BYP_W + $bits(match_cand_t);
  localparam int PTR_W = slot_width(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int BUSY_W = $clog2(FIFO_DEPTH + LAYER + 1);

  // Node 0 is the root; it is formed on the way into the FIFO and never stored.
  match_cand_t        node_q [1:TREE_SIZE-1];
  match_cand_t        root;
  logic [LAYER-2:0]   stage_vld_q;
  logic [BYP_W-1:0]   byp_q [LAYER-1];
  logic [FIFO_W-1:0]  fifo_q [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic [BUSY_W-1:0]  busy;
  logic               push;
  logic               pop;

  // Longer match wins, then the more recent address. Two empty children give an empty parent.
  function automatic match_cand_t pick(input match_cand_t a, input match_cand_t b);
    if (a.valid && b.valid) begin
      if (a.len > b.len) return a;
      if (a.len == b.len && a.addr > b.addr) return a;
      return b;
    end
    if (a.valid) return a;
    if (b.valid) return b;
    return '0;
  endfunction

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign root = pick(node_q[1], node_q[2]);
  assign push = stage_vld_q[LAYER-2];
  assign out_valid = (count_q != '0);
  assign pop = out_valid && out_ready;

  always_ff @(posedge clk) begin
    byp_q[0] <= {cand_pos, cand_data};
    for (int k = 1; k < LAYER - 1; k++) begin
      byp_q[k] <= byp_q[k-1];
    end
    for (int i = 0; i < LEAF_SIZE; i++) begin
      if (i < ROW_SIZE) node_q[LEAF_SIZE - 1 + i] <= cand_row[i];
      else node_q[LEAF_SIZE - 1 + i] <= '0; // Padding leaf.
    end
    for (int i = 1; i < LEAF_SIZE - 1; i++) begin
      node_q[i] <= pick(node_q[2*i + 1], node_q[2*i + 2]);
    end
    if (push) fifo_q[wr_ptr_q] <= {byp_q[LAYER-2], root};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_vld_q <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      stage_vld_q[0] <= cand_valid;
      for (int k = 1; k < LAYER - 1; k++) begin
        stage_vld_q[k] <= stage_vld_q[k-1];
      end
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Everything already past the lookup must still find a FIFO slot.
  always_comb begin
    busy = BUSY_W'(count_q) + BUSY_W'(cand_valid);
    for (int k = 0; k < LAYER - 1; k++) begin
      busy = busy + BUSY_W'(stage_vld_q[k]);
    end
  end
  assign space_ok = (busy < BUSY_W'(FIFO_DEPTH));

  assign {out_pos, out_data, out_hit, out_match_addr, out_match_len, out_can_ext} =
    fifo_q[rd_ptr_q];

  assert property (@(posedge clk) disable iff (!rst_n) push |-> count_q < CNT_W'(FIFO_DEPTH))
    else $error("Merge pushed into a full FIFO.");

endmodule

// ==== hw/match_finder_top.sv ====
`timescale 1ns/1ps

module match_finder_top import lz_cfg_pkg::*, lz_types_pkg::*; #(
  parameter int ROW_SIZE = DEFAULT_ROW_SIZE
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic [ADDR_WIDTH-1:0] in_pos,
  input  logic [DATA_WIDTH-1:0] in_data,
  output logic                  in_ready,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [ADDR_WIDTH-1:0] out_pos,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  out_hit,
  output logic [ADDR_WIDTH-1:0] out_match_addr,
  output logic [LEN_WIDTH-1:0]  out_match_len,
  output logic                  out_can_ext
);

  logic                       space_ok;
  logic                       cand_valid;
  match_cand_t [ROW_SIZE-1:0] cand_row;
  logic [ADDR_WIDTH-1:0]      cand_pos;
  logic [DATA_WIDTH-1:0]      cand_data;
  logic                       ins_valid;
  logic [HASH_BITS-1:0]       ins_row;
  logic [ADDR_WIDTH-1:0]      ins_pos;
  logic [DATA_WIDTH-1:0]      ins_data;

  row_access_if #(.ROW_SIZE(ROW_SIZE)) lk_port ();
  row_access_if #(.ROW_SIZE(ROW_SIZE)) ins_port ();

  hash_row_table #(.ROW_SIZE(ROW_SIZE)) i_hash_row_table (
    .clk, .rst_n, .lk_port(lk_port), .ins_port(ins_port)
  );

  hash_row_lookup #(.ROW_SIZE(ROW_SIZE)) i_hash_row_lookup (
    .clk, .rst_n, .in_valid, .in_pos, .in_data, .in_ready, .space_ok, .mem(lk_port),
    .cand_valid, .cand_row, .cand_pos, .cand_data, .ins_valid, .ins_row, .ins_pos, .ins_data
  );

  hash_row_insert #(.ROW_SIZE(ROW_SIZE)) i_hash_row_insert (
    .clk, .rst_n, .ins_valid, .ins_row, .ins_pos, .ins_data, .mem(ins_port)
  );

  hash_row_merge #(.ROW_SIZE(ROW_SIZE)) i_hash_row_merge (
    .clk, .rst_n, .cand_valid, .cand_row, .cand_pos, .cand_data, .space_ok,
    .out_valid, .out_ready, .out_pos, .out_data, .out_hit, .out_match_addr,
    .out_match_len, .out_can_ext
  );

endmodule

// ==== verif/tb_match_finder.sv ====
`timescale 1ns/1ps

module tb_match_finder import lz_cfg_pkg::*; ();

  localparam int N_TESTS = 20;
  localparam int ROW_SIZE = DEFAULT_ROW_SIZE;
  localparam int TIMEOUT = 200; // Cycles allowed for any single handshake.

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic [ADDR_WIDTH-1:0] in_pos;
  logic [DATA_WIDTH-1:0] in_data;
  logic                  in_ready;
  logic                  out_valid;
  logic                  out_ready;
  logic [ADDR_WIDTH-1:0] out_pos;
  logic [DATA_WIDTH-1:0] out_data;
  logic                  out_hit;
  logic [ADDR_WIDTH-1:0] out_match_addr;
  logic [LEN_WIDTH-1:0]  out_match_len;
  logic                  out_can_ext;

  logic [ADDR_WIDTH-1:0] t_pos [N_TESTS];
  logic [DATA_WIDTH-1:0] t_data [N_TESTS];
  logic                  t_hit [N_TESTS];
  logic [ADDR_WIDTH-1:0] t_addr [N_TESTS];
  logic [LEN_WIDTH-1:0]  t_len [N_TESTS];
  logic                  t_ext [N_TESTS];

  int errors;
  int test_errors;
  int passed;
  bit timed_out;
  bit checks_done;

  match_finder_top #(.ROW_SIZE(ROW_SIZE)) i_match_finder_top (
    .clk, .rst_n, .in_valid, .in_pos, .in_data, .in_ready, .out_valid, .out_ready,
    .out_pos, .out_data, .out_hit, .out_match_addr, .out_match_len, .out_can_ext
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Rows 0 to 5 and 19 share one hash row, rows 6 to 10 and 15 to 16 another.
  function automatic logic [ADDR_WIDTH+DATA_WIDTH-1:0] stim_word(input int i);
    case (i)
      0: return {16'h0100, 32'h84434241}; // Empty row.
      1: return {16'h0110, 32'h44434241};
      2: return {16'h0120, 32'h54434241}; // Tie at three bytes.
      3: return {16'h0130, 32'h44434241}; // Full repeat beats a later partial.
      4: return {16'h0140, 32'h64434241}; // Fifth insert evicts 0100.
      5: return {16'h0150, 32'h84434241};
      6: return {16'h0200, 32'h00000011};
      7: return {16'h0210, 32'h00001011};
      8: return {16'h0220, 32'h00100011};
      9: return {16'h0230, 32'h00000021}; // Same row, byte 0 never matches.
      10: return {16'h0240, 32'h10000011};
      11: return {16'h0300, 32'h00000000};
      12: return {16'h0310, 32'h0f0f0f0f};
      13: return {16'h0320, 32'h00000000};
      14: return {16'h0330, 32'h0f0f0f0f};
      15: return {16'h0340, 32'h00000011};
      16: return {16'h0350, 32'h10000011};
      17: return {16'h0360, 32'hdeadbeef};
      18: return {16'h0370, 32'hdeadbeef};
      19: return {16'h0380, 32'h44434241};
      default: return '0;
    endcase
  endfunction

  function automatic logic [HASH_BITS-1:0] ref_row(input logic [DATA_WIDTH-1:0] d);
    logic [10:0] h;
    h = {3'b0, d[7:0]} ^ {2'b0, d[15:8], 1'b0} ^ {1'b0, d[23:16], 2'b0} ^ {d[31:24], 3'b0};
    return h[HASH_BITS-1:0];
  endfunction

  function automatic int lead_bytes(input logic [DATA_WIDTH-1:0] stored,
                                    input logic [DATA_WIDTH-1:0] cur);
    int n;
    n = 0;
    while (n < PREFIX_BYTES && stored[8*n +: 8] == cur[8*n +: 8]) begin
      n++;
    end
    return n;
  endfunction

  // Replays the history table in input order to fill in the expected columns.
  task automatic build_expected();
    logic [ADDR_WIDTH-1:0] h_addr [NUM_ROWS][ROW_SIZE];
    logic [DATA_WIDTH-1:0] h_data [NUM_ROWS][ROW_SIZE];
    bit                    h_vld [NUM_ROWS][ROW_SIZE];
    int                    next_slot [NUM_ROWS];
    int                    r;
    int                    len;
    for (int k = 0; k < NUM_ROWS; k++) begin
      next_slot[k] = 0;
      for (int s = 0; s < ROW_SIZE; s++) begin
        h_vld[k][s] = 1'b0;
      end
    end
    for (int i = 0; i < N_TESTS; i++) begin
      {t_pos[i], t_data[i]} = stim_word(i);
      r = ref_row(t_data[i]);
      t_hit[i] = 1'b0;
      t_addr[i] = '0;
      t_len[i] = '0;
      for (int s = 0; s < ROW_SIZE; s++) begin
        len = h_vld[r][s] ? lead_bytes(h_data[r][s], t_data[i]) : 0;
        if (len > 0 && (!t_hit[i] || len > t_len[i] ||
                        (len == t_len[i] && h_addr[r][s] > t_addr[i]))) begin
          t_hit[i] = 1'b1;
          t_addr[i] = h_addr[r][s];
          t_len[i] = LEN_WIDTH'(len);
        end
      end
      t_ext[i] = (t_len[i] == PREFIX_BYTES);
      h_vld[r][next_slot[r]] = 1'b1;
      h_addr[r][next_slot[r]] = t_pos[i];
      h_data[r][next_slot[r]] = t_data[i];
      next_slot[r] = (next_slot[r] + 1) % ROW_SIZE; // Oldest entry goes next.
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic send_all();
    int wait_cycles;
    @(posedge clk);
    for (int i = 0; i < N_TESTS; i++) begin
      in_valid <= 1'b1;
      in_pos <= t_pos[i];
      in_data <= t_data[i];
      wait_cycles = 0;
      @(negedge clk);
      while (!in_ready && wait_cycles < TIMEOUT) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (!in_ready) begin
        $display("Input %0d was never accepted, in_ready stayed low.", i);
        timed_out = 1'b1;
        errors++;
        break;
      end
      @(posedge clk); // Acceptance edge.
    end
    in_valid <= 1'b0;
  endtask

  task automatic collect_all();
    int wait_cycles;
    for (int i = 0; i < N_TESTS; i++) begin
      wait_cycles = 0;
      @(negedge clk);
      while (!(out_valid && out_ready) && wait_cycles < TIMEOUT && !timed_out) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (!(out_valid && out_ready)) begin
        $display("No output arrived for test %0d before the timeout.", i);
        timed_out = 1'b1;
        errors++;
        break;
      end
      test_errors = 0;
      check_value("out_pos", 32'(t_pos[i]), 32'(out_pos));
      check_value("out_data", t_data[i], out_data);
      check_value("out_hit", 32'(t_hit[i]), 32'(out_hit));
      check_value("out_match_addr", 32'(t_addr[i]), 32'(out_match_addr));
      check_value("out_match_len", 32'(t_len[i]), 32'(out_match_len));
      check_value("out_can_ext", 32'(t_ext[i]), 32'(out_can_ext));
      errors += test_errors;
      if (test_errors == 0) passed++;
      $display("Test %0d pos %h hit %0d addr %h len %0d: %s", i, t_pos[i], t_hit[i],
               t_addr[i], t_len[i], (test_errors == 0) ? "ok" : "mismatch");
    end
    // Nothing may follow the last item.
    repeat (20) begin
      @(negedge clk);
      if (out_valid && !timed_out) begin
        $display("An extra output appeared after the last expected item.");
        errors++;
        break;
      end
    end
    checks_done = 1'b1;
  endtask

  task automatic drive_out_ready();
    while (!checks_done) begin
      @(posedge clk);
      out_ready <= ($urandom % 3) != 0;
    end
  endtask

  initial begin
    void'($urandom(58));
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_pos = '0;
    in_data = '0;
    out_ready = 1'b0;
    errors = 0;
    passed = 0;
    timed_out = 1'b0;
    checks_done = 1'b0;
    build_expected();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    fork
      send_all();
      collect_all();
      drive_out_ready();
    join
    $display("Tests run %0d, passed %0d, errors %0d", N_TESTS, passed, errors);
    if (errors == 0 && passed == N_TESTS && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hw/lz_cfg_pkg.sv
hw/lz_types_pkg.sv
hw/row_access_if.sv
hw/hash_row_table.sv
hw/hash_row_lookup.sv
hw/hash_row_insert.sv
hw/hash_row_merge.sv
hw/match_finder_top.sv
verif/tb_match_finder.sv

// ==== Bender.yml ====
package:
  name: match_finder

sources:
  - files:
      - hw/lz_cfg_pkg.sv
      - hw/lz_types_pkg.sv
      - hw/row_access_if.sv
      - hw/hash_row_table.sv
      - hw/hash_row_lookup.sv
      - hw/hash_row_insert.sv
      - hw/hash_row_merge.sv
      - hw/match_finder_top.sv
  - target: test
    files:
      - verif/tb_match_finder.sv
